// File: files.f
verilog/spi_cfg_pkg.sv
verilog/spi_ctrl_pkg.sv
verilog/sck_divider.sv
verilog/spi_shifter.sv
verilog/spi_sequencer.sv
verilog/spi_master.sv
tests/spi_master_assertions.sv
tests/spi_master_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the spi master testbench with verilator
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert \
    --top-module spi_master_tb \
    --Mdir "$build_dir" -o spi_master_sim \
    -f files.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

"./$build_dir/spi_master_sim" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

# the testbench prints its pass line only when every check held
if grep -qx "sim passed" "$log_file"; then
    echo "result: PASS"
    exit 0
fi
echo "result: FAIL"
exit 1

// File: tests/spi_master_assertions.sv
`timescale 1ns/1ps

module spi_master_assertions
    import spi_cfg_pkg::*;
    import spi_ctrl_pkg::*;
(
    input logic                 clk,
    input logic                 reset,
    input logic                 sck,
    input logic                 sel,
    input logic                 busy,
    input logic                 valid,
    input logic [word_bits-1:0] data_out
);

    // transfer phase as seen from the pins
    spi_state_e pin_state;

    assign pin_state = busy ? st_shift : (valid ? st_done : st_idle);

    // sck idles low outside a transfer
    sck_idle_low: assert property (@(posedge clk) disable iff (reset) !busy |-> !sck)
        else $error("sck high while the master is not busy");

    sel_is_busy: assert property (@(posedge clk) disable iff (reset) sel == busy)
        else $error("sel and busy disagree");

    valid_not_busy: assert property (@(posedge clk) disable iff (reset) !(valid && busy))
        else $error("valid and busy high together");

    data_gated: assert property (@(posedge clk) disable iff (reset) !valid |-> data_out == '0)
        else $error("data_out nonzero while valid is low");

    // a word can only complete through the shift phase
    no_skip_shift: assert property (@(posedge clk) disable iff (reset)
        pin_state == st_idle |=> pin_state != st_done)
        else $error("valid rose without a transfer");

endmodule

bind spi_master spi_master_assertions u_assertions (
    .clk      (clk),
    .reset    (reset),
    .sck      (sck),
    .sel      (sel),
    .busy     (busy),
    .valid    (valid),
    .data_out (data_out)
);

// File: tests/spi_master_tb.sv
`timescale 1ns/1ps

module spi_master_tb import spi_cfg_pkg::*; ();

    localparam int transfer_count = 40;
    // one full word of sck periods plus start detection slack
    localparam int wait_limit = 2 * sck_half_cycles * word_bits + 16;

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 en;
    logic                 start;
    logic                 miso = 1'b0;
    logic [word_bits-1:0] data_in;
    logic                 sck;
    logic                 mosi;
    logic                 sel;
    logic                 busy;
    logic                 valid;
    logic [word_bits-1:0] data_out;

    logic [15:0]          lfsr_state = 16'd54736;
    int                   value_errors = 0;
    int                   timeout_errors = 0;
    logic                 hold_valid = 1'b0;
    logic [word_bits-1:0] last_resp = '0;

    // slave model state
    logic [word_bits-1:0] resp_word = '0;
    logic [word_bits-1:0] miso_shift = '0;
    logic [word_bits-1:0] mosi_word = '0;
    logic                 sel_prev = 1'b0;
    logic                 sck_prev = 1'b0;
    int                   rise_count = 0;
    int                   sel_rises = 0;

    spi_master DUT (
        .clk      (clk),
        .reset    (reset),
        .en       (en),
        .start    (start),
        .miso     (miso),
        .data_in  (data_in),
        .sck      (sck),
        .mosi     (mosi),
        .sel      (sel),
        .busy     (busy),
        .valid    (valid),
        .data_out (data_out)
    );

    always #4 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [word_bits-1:0] random_bits(input int n);
        logic [word_bits-1:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[word_bits-2:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // spi slave model sampling the pins 1 ns after each clk edge
    always @(posedge clk) begin
        #1;
        if (sel && !sel_prev) begin
            sel_rises++;
            rise_count = 0;
            mosi_word = '0;
            miso_shift = resp_word;
            miso = resp_word[word_bits-1];
        end else if (sel && sck && !sck_prev) begin
            mosi_word = {mosi_word[word_bits-2:0], mosi};
            rise_count++;
        end else if (sel && !sck && sck_prev) begin
            miso_shift = {miso_shift[word_bits-2:0], 1'b0};
            miso = miso_shift[word_bits-1];
        end
        sel_prev = sel;
        sck_prev = sck;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual == expected) else begin
            value_errors++;
            $display("FAILED time=%0t signal=%s expected=0x%0h actual=0x%0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic wait_busy();
        int cycles;
        cycles = 0;
        while (busy !== 1'b1 && cycles < wait_limit) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        assert (busy === 1'b1) else begin
            timeout_errors++;
            $display("timeout at %0t: the transfer never started after the start edge", $time);
        end
    endtask

    task automatic wait_valid();
        int cycles;
        cycles = 0;
        while (valid !== 1'b1 && cycles < wait_limit) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        assert (valid === 1'b1) else begin
            timeout_errors++;
            $display("timeout at %0t: valid never came up at the end of the word", $time);
        end
    endtask

    task automatic wait_quiet();
        int cycles;
        cycles = 0;
        while ((busy | sel | sck | valid) !== 1'b0 && cycles < wait_limit) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        assert ((busy | sel | sck | valid) === 1'b0) else begin
            timeout_errors++;
            $display("timeout at %0t: the master did not go quiet after en dropped", $time);
        end
    endtask

    task automatic run_transfer(input bit do_abort);
        logic [word_bits-1:0] tx_word;
        int gap;
        int rises_before;
        tx_word = random_bits(word_bits);
        resp_word = random_bits(word_bits);
        data_in = tx_word;
        gap = int'(random_bits(3)) + 1;
        // previous word must stay visible until the next start edge
        for (int i = 0; i < gap; i++) begin
            if (hold_valid) begin
                check_value("valid", 32'd1, 32'(valid));
                check_value("data_out", 32'(last_resp), 32'(data_out));
            end
            @(posedge clk);
            #1;
        end
        rises_before = sel_rises;
        start = 1'b1;
        wait_busy();
        check_value("valid", 32'd0, 32'(valid));
        check_value("data_out", 32'd0, 32'(data_out));
        if (random_bits(1) != '0) begin
            // a second start edge while busy must not restart
            start = 1'b0;
            repeat (2) @(posedge clk);
            #1;
            start = 1'b1;
        end
        if (do_abort) begin
            repeat (int'(random_bits(6)) + 2) @(posedge clk);
            #1;
            en = 1'b0;
            start = 1'b0;
            wait_quiet();
            check_value("data_out", 32'd0, 32'(data_out));
            check_value("mosi", 32'd0, 32'(mosi));
            en = 1'b1;
            hold_valid = 1'b0;
        end else begin
            wait_valid();
            check_value("data_out", 32'(resp_word), 32'(data_out));
            check_value("mosi_word", 32'(tx_word), 32'(mosi_word));
            check_value("sck_rises", word_bits, rise_count);
            check_value("sel_rises", rises_before + 1, sel_rises);
            start = 1'b0;
            last_resp = resp_word;
            hold_valid = 1'b1;
        end
    endtask

    initial begin
        reset = 1'b1;
        en = 1'b0;
        start = 1'b0;
        data_in = '0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        en = 1'b1;
        // enabled but never started so all outputs stay at rest
        repeat (8) begin
            @(posedge clk);
            #1;
            check_value("sck", 32'd0, 32'(sck));
            check_value("sel", 32'd0, 32'(sel));
            check_value("busy", 32'd0, 32'(busy));
            check_value("valid", 32'd0, 32'(valid));
            check_value("mosi", 32'd0, 32'(mosi));
            check_value("data_out", 32'd0, 32'(data_out));
        end
        for (int n = 0; n < transfer_count; n++) begin
            run_transfer((random_bits(3) == '0) || (n == 7));
        end
        $display("errors: %0d value mismatches, %0d timeouts", value_errors, timeout_errors);
        if (value_errors + timeout_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: verilog/sck_divider.sv
`timescale 1ns/1ps

module sck_divider import spi_cfg_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic run,
    output logic sck,
    output logic sck_rise,
    output logic sck_fall
);

    // one spare bit so a half period of one clk still has a valid width
    logic [$clog2(sck_half_cycles + 1)-1:0] half_cnt;
    logic sck_q;
    logic rise_q;
    logic fall_q;
    logic half_done;

    assign half_done = (int'(half_cnt) == sck_half_cycles - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            half_cnt <= '0;
            sck_q    <= 1'b0;
            rise_q   <= 1'b0;
            fall_q   <= 1'b0;
        end else if (!run) begin
            // park in the low phase so the next transfer starts clean
            half_cnt <= '0;
            sck_q    <= 1'b0;
            rise_q   <= 1'b0;
            fall_q   <= 1'b0;
        end else begin
            rise_q <= 1'b0;
            fall_q <= 1'b0;
            if (half_done) begin
                half_cnt <= '0;
                sck_q    <= ~sck_q;
                // pulses line up with the cycle sck changes
                rise_q   <= ~sck_q;
                fall_q   <= sck_q;
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end
        end
    end

    // an abort drops run one cycle before the registers clear
    assign sck      = sck_q & run;
    assign sck_rise = rise_q & run;
    assign sck_fall = fall_q & run;

endmodule

// File: verilog/spi_cfg_pkg.sv
package spi_cfg_pkg;

    // bits shifted out and in per transfer
    localparam int word_bits = 16;

    // bit counter must be able to hold word_bits itself
    localparam int bit_count_bits = 5;

    // clk cycles per sck half period
    // sck frequency is clk / (2 * sck_half_cycles)
    localparam int sck_half_cycles = 4;

endpackage

// File: verilog/spi_ctrl_pkg.sv
package spi_ctrl_pkg;

    // transfer sequencer states
    // st_done holds the received word with valid high
    typedef enum logic [1:0] {
        st_idle  = 2'd0,
        st_shift = 2'd1,
        st_done  = 2'd2
    } spi_state_e;

endpackage

// File: verilog/spi_master.sv
`timescale 1ns/1ps

module spi_master import spi_cfg_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 en,
    input  logic                 start,
    input  logic                 miso,
    input  logic [word_bits-1:0] data_in,
    output logic                 sck,
    output logic                 mosi,
    output logic                 sel,
    output logic                 busy,
    output logic                 valid,
    output logic [word_bits-1:0] data_out
);

    logic run;
    logic load;
    logic sck_rise;
    logic sck_fall;

    // control module owning the state and the en check
    spi_sequencer u_sequencer (
        .clk      (clk),
        .reset    (reset),
        .en       (en),
        .start    (start),
        .sck_fall (sck_fall),
        .run      (run),
        .load     (load),
        .busy     (busy),
        .sel      (sel),
        .valid    (valid)
    );

    spi_shifter u_shifter (
        .clk      (clk),
        .reset    (reset),
        .load     (load),
        .run      (run),
        .sck_rise (sck_rise),
        .sck_fall (sck_fall),
        .miso     (miso),
        .valid    (valid),
        .data_in  (data_in),
        .mosi     (mosi),
        .data_out (data_out)
    );

    // sck and its edge pulses only toggle while run is high
    sck_divider u_divider (
        .clk      (clk),
        .reset    (reset),
        .run      (run),
        .sck      (sck),
        .sck_rise (sck_rise),
        .sck_fall (sck_fall)
    );

endmodule

// File: verilog/spi_sequencer.sv
`timescale 1ns/1ps

module spi_sequencer
    import spi_cfg_pkg::*;
    import spi_ctrl_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic en,
    input  logic start,
    input  logic sck_fall,
    output logic run,
    output logic load,
    output logic busy,
    output logic sel,
    output logic valid
);

    logic [1:0]                start_q;
    logic                      start_edge;
    logic                      last_fall;
    logic [bit_count_bits-1:0] bit_cnt;
    spi_state_e                state;
    spi_state_e                state_next;

    // two stage start register with the older sample in bit 1
    always_ff @(posedge clk) begin
        if (reset) begin
            start_q <= 2'b00;
        end else begin
            start_q <= {start_q[0], start};
        end
    end

    assign start_edge = (start_q == 2'b01);

    // falling edge that completes the last bit of the word
    assign last_fall = sck_fall && (int'(bit_cnt) == word_bits - 1);

    // a start edge only counts when enabled and not already shifting
    assign load = en && start_edge && (state != st_shift);

    always_comb begin
        state_next = state;
        if (!en) begin
            state_next = st_idle;
        end else begin
            case (state)
                st_idle, st_done: begin
                    if (start_edge) begin
                        state_next = st_shift;
                    end
                end
                st_shift: begin
                    if (last_fall) begin
                        state_next = st_done;
                    end
                end
                default: begin
                    state_next = st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    // counts falling edges of sck during the shift phase
    always_ff @(posedge clk) begin
        if (reset) begin
            bit_cnt <= '0;
        end else if (!en || load) begin
            bit_cnt <= '0;
        end else if ((state == st_shift) && sck_fall) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // all transfer levels are plain state decodes
    assign run   = (state == st_shift);
    assign busy  = run;
    assign sel   = run;
    assign valid = (state == st_done);

endmodule

// File: verilog/spi_shifter.sv
`timescale 1ns/1ps

module spi_shifter import spi_cfg_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 load,
    input  logic                 run,
    input  logic                 sck_rise,
    input  logic                 sck_fall,
    input  logic                 miso,
    input  logic                 valid,
    input  logic [word_bits-1:0] data_in,
    output logic                 mosi,
    output logic [word_bits-1:0] data_out
);

    logic [word_bits-1:0] tx_reg;
    logic [word_bits-1:0] rx_reg;
    logic                 miso_q;

    // miso is registered every clk and shifted in on sck_rise
    always_ff @(posedge clk) begin
        miso_q <= miso;
    end

    // transmit register sends the MSB first
    always_ff @(posedge clk) begin
        if (load) begin
            tx_reg <= data_in;
        end else if (sck_fall) begin
            // next bit moves up to the MSB after each falling edge
            tx_reg <= {tx_reg[word_bits-2:0], 1'b0};
        end
    end

    // first received bit ends up as the receive MSB
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_reg <= '0;
        end else if (load) begin
            rx_reg <= '0;
        end else if (sck_rise) begin
            rx_reg <= {rx_reg[word_bits-2:0], miso_q};
        end
    end

    // mosi stays low between transfers
    assign mosi = run & tx_reg[word_bits-1];

    // received word only visible while valid
    assign data_out = valid ? rx_reg : '0;

endmodule
